//--- build.f
+incdir+logic
logic/game_pkg.sv
logic/game_keys.sv
logic/game_sprite.sv
logic/game_overlap.sv
logic/game_master_fsm.sv
logic/game_mixer.sv
logic/game_top.sv
dv/game_tb.sv

//--- dv/game_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "game_defs.svh"

module game_tb import game_pkg::*;
();

    // a tall screen lets the torpedo outlive both target bounces
    localparam int screen_w      = 64;
    localparam int screen_h      = 128;
    localparam int strobe_width  = 5;
    localparam int strobe_cycles = 1 << strobe_width;
    localparam int win_len       = 200;
    localparam int size          = `GAME_SPRITE_SIZE;
    localparam int game_cycles   = 100 * strobe_cycles + win_len + 50;
    localparam int cycle_limit   = 2 * (10 + 100 + 4 * (game_cycles + 110));

    logic       clk = 1'b0;
    logic       reset;
    logic       launch_key;
    logic [1:0] left_right_keys;
    logic       display_on;
    coord_x_t   x;
    coord_y_t   y;
    rgb_t       rgb;

    int          cycles = 0;
    int          pixel_errors;
    int          blank_errors;
    int          checks;
    int          tx, ty, tdx, tdy, px, py, pdx;
    int          ge, end_edge, remain;
    game_state_t model_state, end_state;
    bit          in_game, pending;
    rgb_t        expected;

    game_top #(
        .screen_width  ( screen_w     ),
        .screen_height ( screen_h     ),
        .strobe_width  ( strobe_width ),
        .win_cycles    ( win_len      )
    )
    game_top_i
    (
        .clk             ( clk             ),
        .reset           ( reset           ),
        .launch_key      ( launch_key      ),
        .left_right_keys ( left_right_keys ),
        .display_on      ( display_on      ),
        .x               ( x               ),
        .y               ( y               ),
        .rgb             ( rgb             )
    );

    always #20 clk = ~clk;

    always @(posedge clk)
        cycles <= cycles + 1;

    initial
    begin
        while (cycles < cycle_limit)
            @(posedge clk);
        $display("run stopped after %0d cycles without finishing the games", cycles);
        $display("Test failed");
        $finish;
    end

    // blanked pixels come out black one cycle later
    blank_check: assert property (@(posedge clk) disable iff (reset)
                                  !$past(display_on) |-> rgb == '0)
        else
        begin
            blank_errors++;
            $display("FAILED rgb after blanking: got %h expected %h", rgb, 3'h0);
        end

    function automatic int steer_dx(logic [1:0] keys);
        case (keys)
        2'b01:   return 1;
        2'b10:   return -1;
        default: return 0;
        endcase
    endfunction

    // a sprite that wrapped past zero draws nothing
    function automatic bit in_square(int xp, int yp, int sx, int sy);
        return sx >= 0 && sy >= 0 && xp >= sx && xp < sx + size && yp >= sy && yp < sy + size;
    endfunction

    function automatic rgb_t predict_rgb(int xp, int yp, bit on);
        bit show;
        show = (model_state == state_play) && ge >= 3;
        if (!on)
            return '0;
        if (model_state == state_won)
            return `GAME_COLOR_WON;
        if (show && in_square(xp, yp, px, py))
            return `GAME_COLOR_TORPEDO;
        if (show && in_square(xp, yp, tx, ty))
            return `GAME_COLOR_TARGET;
        return `GAME_COLOR_BACKGROUND;
    endfunction

    task automatic move_sprites();
        tx  += tdx;
        ty  += tdy;
        px  += pdx;
        py  -= 1;
        tdy  = 0;
        if (tdx == 1 && tx + size >= screen_w)
        begin
            tdx = -1;
            tdy = 1;  // reverse and step down on the next move
        end
        else if (tdx == -1 && tx == 0)
        begin
            tdx = 1;
            tdy = 1;
        end
        if (px < 0 || px > screen_w - size || py < 0 || py > screen_h - size)
        begin
            end_edge  = ge + 1;
            end_state = state_idle;
        end
        else if (!(tx + size <= px || px + size <= tx || ty + size <= py || py + size <= ty))
        begin
            end_edge  = ge + 2;  // collision is registered before the FSM sees it
            end_state = state_won;
        end
    endtask

    // advances the model over the rising edge that just passed
    task automatic step_model();
        if (in_game)
        begin
            ge++;
            if (ge == 2)
                model_state = state_play;
            if (ge == 3)
            begin
                tx  = screen_w / 4;
                ty  = 0;
                px  = screen_w / 2;
                py  = screen_h - `GAME_TORPEDO_RISE;
                tdx = 1;
                tdy = 0;
            end
            if (model_state == state_play && ge > 3 && (ge - 3) % strobe_cycles == 0)
                move_sprites();
            if (ge == end_edge)
            begin
                model_state = end_state;
                remain      = win_len;
                in_game     = (end_state == state_won);
            end
            else if (model_state == state_won)
            begin
                remain--;
                if (remain == 0)
                begin
                    model_state = state_idle;
                    in_game     = 0;
                end
            end
        end
    endtask

    task automatic drive_probe();
        int pick;
        int xp;
        int yp;
        pick = $urandom % 8;
        xp   = $urandom % screen_w;
        yp   = $urandom % screen_h;
        case (pick)
        1, 2:
        begin
            xp = (tx + screen_w - 3 + int'($urandom % 22)) % screen_w;
            yp = (ty + screen_h - 3 + int'($urandom % 22)) % screen_h;
        end
        3, 4:
        begin
            xp = (px + screen_w - 3 + int'($urandom % 22)) % screen_w;
            yp = (py + screen_h - 3 + int'($urandom % 22)) % screen_h;
        end
        5:
        begin
            xp = (tx + size / 2) % screen_w;  // target centre
            yp = (ty + size / 2) % screen_h;
        end
        6:
        begin
            xp = (px + screen_w + size / 2) % screen_w;
            yp = (py + screen_h + size / 2) % screen_h;
        end
        default: ;
        endcase
        display_on = (pick != 0);
        x          = coord_x_t'(xp);
        y          = coord_y_t'(yp);
        expected   = predict_rgb(xp, yp, display_on);
    endtask

    task automatic tick();
        @(negedge clk);
        step_model();
        if (pending)
        begin
            checks++;
            pixel_check: assert (rgb == expected)
                else
                begin
                    pixel_errors++;
                    $display("FAILED rgb at x=%h y=%h: got %h expected %h", x, y, rgb, expected);
                end
        end
        drive_probe();
        pending = 1;
    endtask

    initial
    begin
        int offset;
        void'($urandom(72));
        reset           = 1'b1;
        launch_key      = 1'b0;
        left_right_keys = 2'b00;
        display_on      = 1'b0;
        x               = '0;
        y               = '0;
        pixel_errors    = 0;
        blank_errors    = 0;
        checks          = 0;
        pending         = 0;
        in_game         = 0;
        model_state     = state_idle;
        {tx, ty, tdx, tdy, px, py, pdx} = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        repeat (100) tick();

        // every key combination gets one game, in a random order
        offset = $urandom % 4;
        for (int g = 0; g < 4; g++)
        begin
            left_right_keys = 2'((offset + g) % 4);
            pdx             = steer_dx(left_right_keys);
            repeat (5) tick();
            launch_key = 1'b1;
            in_game    = 1;
            ge         = -1;
            end_edge   = -1;
            repeat (4) tick();
            launch_key = 1'b0;
            while (in_game)
                tick();
            repeat (100) tick();
        end

        $display("checks %0d, pixel errors %0d, blanking errors %0d",
                 checks, pixel_errors, blank_errors);
        if (pixel_errors == 0 && blank_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/game_defs.svh
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// pixel and coordinate widths
`define GAME_RGB_WIDTH 3
`define GAME_X_WIDTH   10
`define GAME_Y_WIDTH   9

// both sprites are solid squares of this side
`define GAME_SPRITE_SIZE 16

// torpedo start row sits this far above the bottom edge
`define GAME_TORPEDO_RISE 20

`define GAME_COLOR_BACKGROUND 3'b001
`define GAME_COLOR_TARGET     3'b110
`define GAME_COLOR_TORPEDO    3'b011

// whole screen takes this colour while the win timer runs
`define GAME_COLOR_WON 3'b010

`endif

//--- logic/game_keys.sv
`timescale 1ns/100ps
`default_nettype none

module game_keys import game_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              launch_key,
    input  logic [1:0]        left_right_keys,  // bit 1 is left, bit 0 is right
    output logic              launch,
    output torpedo_velocity_t torpedo_velocity
);

    logic       launch_key_q;
    logic       launch_key_qq;
    logic [1:0] keys_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            launch_key_q     <= 1'b0;
            launch_key_qq    <= 1'b0;
            keys_q           <= 2'b00;
            launch           <= 1'b0;
            torpedo_velocity <= '0;
        end
        else
        begin
            launch_key_q  <= launch_key;
            launch_key_qq <= launch_key_q;
            keys_q        <= left_right_keys;
            launch        <= launch_key_q & ~launch_key_qq;  // one pulse per press

            // the torpedo always climbs, the keys only steer it
            torpedo_velocity.dy <= -2'sd1;

            case (keys_q)
            2'b01:   torpedo_velocity.dx <= 2'sd1;
            2'b10:   torpedo_velocity.dx <= -2'sd1;
            default: torpedo_velocity.dx <= 2'sd0;  // none or both pressed
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/game_master_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module game_master_fsm import game_pkg::*;
#(
    parameter screen_width = 640,
    parameter win_cycles   = 2 ** 24
)
(
    input  logic             clk,
    input  logic             reset,
    input  logic             launch,
    input  logic             collision,
    input  logic             torpedo_within_screen,
    input  coord_x_t         target_left,
    input  coord_x_t         target_right,
    output logic             load,
    output logic             show,
    output logic             won,
    output target_velocity_t target_velocity
);

    localparam timer_width = $clog2(win_cycles + 1);

    game_state_t              state;
    logic                     settling;
    logic [timer_width - 1:0] timer;
    coord_x_t                 target_left_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= state_idle;
            load     <= 1'b0;
            settling <= 1'b0;
            timer    <= '0;
        end
        else
        begin
            load     <= 1'b0;
            settling <= load;

            case (state)
            state_idle:
                if (launch)
                begin
                    state <= state_play;
                    load  <= 1'b1;
                end
            state_play:
                // positions and the registered overlap still show the last game here
                if (!load && !settling)
                begin
                    if (collision)
                    begin
                        state <= state_won;
                        timer <= '0;
                    end
                    else if (!torpedo_within_screen)
                        state <= state_idle;
                end
            state_won:
                if (timer == timer_width'(win_cycles - 1))
                    state <= state_idle;
                else
                    timer <= timer + 1'b1;
            default:
                state <= state_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            target_velocity <= '0;
            target_left_q   <= '0;
        end
        else
        begin
            target_left_q <= target_left;

            if (state == state_idle && launch)
            begin
                target_velocity.dx <= 2'sd1;
                target_velocity.dy <= 1'b0;
            end
            else if (state == state_play)
            begin
                if (target_left != target_left_q)
                    target_velocity.dy <= 1'b0;  // the step down has been taken

                // a bounce overrides the clear above when both land on one cycle
                if (target_velocity.dx == -2'sd1 && target_left == '0)
                begin
                    target_velocity.dx <= 2'sd1;
                    target_velocity.dy <= 1'b1;
                end
                else if (target_velocity.dx == 2'sd1
                         && target_right >= coord_x_t'(screen_width - 1))
                begin
                    target_velocity.dx <= -2'sd1;
                    target_velocity.dy <= 1'b1;
                end
            end
        end
    end

    assign show = (state == state_play) && !load;
    assign won  = (state == state_won);

endmodule

`default_nettype wire

//--- logic/game_mixer.sv
`timescale 1ns/100ps
`default_nettype none

`include "game_defs.svh"

module game_mixer import game_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic display_on,
    input  logic won,
    input  logic target_hit,
    input  logic torpedo_hit,
    output rgb_t rgb
);

    rgb_t rgb_next;

    always_comb
    begin
        if (!display_on)
            rgb_next = '0;  // blanking
        else if (won)
            rgb_next = rgb_t'(`GAME_COLOR_WON);
        else if (torpedo_hit)
            rgb_next = rgb_t'(`GAME_COLOR_TORPEDO);
        else if (target_hit)
            rgb_next = rgb_t'(`GAME_COLOR_TARGET);
        else
            rgb_next = rgb_t'(`GAME_COLOR_BACKGROUND);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            rgb <= '0;
        else
            rgb <= rgb_next;
    end

endmodule

`default_nettype wire

//--- logic/game_overlap.sv
`timescale 1ns/100ps
`default_nettype none

module game_overlap import game_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  coord_x_t target_left,
    input  coord_x_t target_right,
    input  coord_y_t target_top,
    input  coord_y_t target_bottom,
    input  coord_x_t torpedo_left,
    input  coord_x_t torpedo_right,
    input  coord_y_t torpedo_top,
    input  coord_y_t torpedo_bottom,
    output logic     collision
);

    logic apart;

    // two rectangles miss only when one lies wholly beside or above the other
    assign apart = (target_right   < torpedo_left) || (torpedo_right  < target_left)
                || (target_bottom  < torpedo_top)  || (torpedo_bottom < target_top);

    always_ff @(posedge clk)
    begin
        if (reset)
            collision <= 1'b0;
        else
            collision <= ~apart;
    end

endmodule

`default_nettype wire

//--- logic/game_pkg.sv
`default_nettype none

`include "game_defs.svh"

package game_pkg;

    typedef logic [`GAME_X_WIDTH   - 1:0] coord_x_t;
    typedef logic [`GAME_Y_WIDTH   - 1:0] coord_y_t;
    typedef logic [`GAME_RGB_WIDTH - 1:0] rgb_t;

    // dy set means step down one row on this move
    typedef struct packed
    {
        logic signed [1:0] dx;
        logic              dy;
    } target_velocity_t;

    typedef struct packed
    {
        logic signed [1:0] dx;
        logic signed [1:0] dy;
    } torpedo_velocity_t;

    typedef enum logic [1:0] {state_idle, state_play, state_won} game_state_t;

endpackage

`default_nettype wire

//--- logic/game_sprite.sv
`timescale 1ns/100ps
`default_nettype none

`include "game_defs.svh"

module game_sprite import game_pkg::*;
#(
    parameter type velocity_t    = torpedo_velocity_t,
    parameter      start_x       = 0,
    parameter      start_y       = 0,
    parameter      screen_width  = 640,
    parameter      screen_height = 480,
    parameter      strobe_width  = 20
)
(
    input  logic      clk,
    input  logic      reset,
    input  logic      load,
    input  logic      show,
    input  velocity_t velocity,
    input  coord_x_t  x,
    input  coord_y_t  y,
    output coord_x_t  left,
    output coord_x_t  right,
    output coord_y_t  top,
    output coord_y_t  bottom,
    output logic      within_screen,
    output logic      hit
);

    localparam size = `GAME_SPRITE_SIZE;

    coord_x_t                  pos_x;
    coord_y_t                  pos_y;
    logic [strobe_width - 1:0] strobe_cnt;
    logic                      strobe;

    // counter wraps on the strobe so moves repeat every 2^strobe_width cycles
    assign strobe = &strobe_cnt;

    always_ff @(posedge clk)
    begin
        if (reset || load)
        begin
            pos_x      <= coord_x_t'(start_x);
            pos_y      <= coord_y_t'(start_y);
            strobe_cnt <= '0;
        end
        else
        begin
            strobe_cnt <= strobe_cnt + 1'b1;

            // signed fields sign extend here, an unsigned dy zero extends
            if (strobe)
            begin
                pos_x <= pos_x + coord_x_t'(velocity.dx);
                pos_y <= pos_y + coord_y_t'(velocity.dy);
            end
        end
    end

    assign left   = pos_x;
    assign right  = pos_x + coord_x_t'(size - 1);
    assign top    = pos_y;
    assign bottom = pos_y + coord_y_t'(size - 1);

    // a move past zero wraps to a large value and also fails these tests
    assign within_screen = (pos_x <= coord_x_t'(screen_width  - size))
                        && (pos_y <= coord_y_t'(screen_height - size));

    assign hit = show
              && (x >= left) && (x <= right)
              && (y >= top)  && (y <= bottom);

endmodule

`default_nettype wire

//--- logic/game_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "game_defs.svh"

module game_top import game_pkg::*;
#(
    parameter screen_width  = 640,
    parameter screen_height = 480,
    parameter strobe_width  = 20,
    parameter win_cycles    = 2 ** 24
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic       launch_key,
    input  logic [1:0] left_right_keys,
    input  logic       display_on,
    input  coord_x_t   x,
    input  coord_y_t   y,
    output rgb_t       rgb
);

    logic              launch;
    torpedo_velocity_t torpedo_velocity;
    target_velocity_t  target_velocity;
    logic              load;
    logic              show;
    logic              won;
    logic              collision;

    coord_x_t target_left,  target_right;
    coord_y_t target_top,   target_bottom;
    coord_x_t torpedo_left, torpedo_right;
    coord_y_t torpedo_top,  torpedo_bottom;
    logic     torpedo_within_screen;
    logic     target_hit, torpedo_hit;

    game_keys keys
    (
        .clk              ( clk              ),
        .reset            ( reset            ),
        .launch_key       ( launch_key       ),
        .left_right_keys  ( left_right_keys  ),
        .launch           ( launch           ),
        .torpedo_velocity ( torpedo_velocity )
    );

    // the target has no loss rule, so its screen flag stays open
    game_sprite
    #(
        .velocity_t    ( target_velocity_t ),
        .start_x       ( screen_width / 4  ),
        .start_y       ( 0                 ),
        .screen_width  ( screen_width      ),
        .screen_height ( screen_height     ),
        .strobe_width  ( strobe_width      )
    )
    sprite_target
    (
        .clk           ( clk             ),
        .reset         ( reset           ),
        .load          ( load            ),
        .show          ( show            ),
        .velocity      ( target_velocity ),
        .x             ( x               ),
        .y             ( y               ),
        .left          ( target_left     ),
        .right         ( target_right    ),
        .top           ( target_top      ),
        .bottom        ( target_bottom   ),
        .within_screen (                 ),
        .hit           ( target_hit      )
    );

    game_sprite
    #(
        .velocity_t    ( torpedo_velocity_t                  ),
        .start_x       ( screen_width / 2                    ),
        .start_y       ( screen_height - `GAME_TORPEDO_RISE  ),
        .screen_width  ( screen_width                        ),
        .screen_height ( screen_height                       ),
        .strobe_width  ( strobe_width                        )
    )
    sprite_torpedo
    (
        .clk           ( clk                   ),
        .reset         ( reset                 ),
        .load          ( load                  ),
        .show          ( show                  ),
        .velocity      ( torpedo_velocity      ),
        .x             ( x                     ),
        .y             ( y                     ),
        .left          ( torpedo_left          ),
        .right         ( torpedo_right         ),
        .top           ( torpedo_top           ),
        .bottom        ( torpedo_bottom        ),
        .within_screen ( torpedo_within_screen ),
        .hit           ( torpedo_hit           )
    );

    game_overlap overlap
    (
        .clk            ( clk            ),
        .reset          ( reset          ),
        .target_left    ( target_left    ),
        .target_right   ( target_right   ),
        .target_top     ( target_top     ),
        .target_bottom  ( target_bottom  ),
        .torpedo_left   ( torpedo_left   ),
        .torpedo_right  ( torpedo_right  ),
        .torpedo_top    ( torpedo_top    ),
        .torpedo_bottom ( torpedo_bottom ),
        .collision      ( collision      )
    );

    game_master_fsm
    #(
        .screen_width ( screen_width ),
        .win_cycles   ( win_cycles   )
    )
    master_fsm
    (
        .clk                   ( clk                   ),
        .reset                 ( reset                 ),
        .launch                ( launch                ),
        .collision             ( collision             ),
        .torpedo_within_screen ( torpedo_within_screen ),
        .target_left           ( target_left           ),
        .target_right          ( target_right          ),
        .load                  ( load                  ),
        .show                  ( show                  ),
        .won                   ( won                   ),
        .target_velocity       ( target_velocity       )
    );

    game_mixer mixer
    (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .display_on  ( display_on  ),
        .won         ( won         ),
        .target_hit  ( target_hit  ),
        .torpedo_hit ( torpedo_hit ),
        .rgb         ( rgb         )
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# compile and run the game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module game_tb -Mdir obj_dir -o game_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator compile step failed"
    exit 1
fi

./obj_dir/game_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "^Test passed$" sim.log; then
    exit 0
fi
exit 1
